/* sources.f */
+incdir+src
src/msx_bus_pkg.sv
src/slot_regs.sv
src/slot_decoder.sv
src/memory_mapper.sv
src/addr_demux.sv
src/strobe_isolation.sv
src/msx_bus_bridge.sv
tb/tb_msx_bus_bridge.sv

/* Bender.yml */
package:
  name: msx_bus_bridge

sources:
  - include_dirs:
      - src
    files:
      - src/msx_bus_pkg.sv
      - src/slot_regs.sv
      - src/slot_decoder.sv
      - src/memory_mapper.sv
      - src/addr_demux.sv
      - src/strobe_isolation.sv
      - src/msx_bus_bridge.sv
  - target: test
    files:
      - tb/tb_msx_bus_bridge.sv

/* tb/tb_msx_bus_bridge.sv */
`timescale 1ns/1ps

module tb_msx_bus_bridge;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;
    localparam int SETTLE_DLY   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int HOLD_PHASES  = 6;
    localparam int IDLE_CYCLES  = 2;
    // external rd/wr open this many clocks after the CPU strobe is first sampled
    localparam int STROBE_DELAY = 3;
    localparam int N_ACCESSES   = 32;
    localparam int TEST_CYCLES  = RESET_CYCLES + 20
                                  + N_ACCESSES * (HOLD_PHASES + 1 + IDLE_CYCLES);

    logic        clk_108m;
    logic        bus_reset_n;
    logic [15:0] cpu_addr;
    logic        cpu_mreq_n;
    logic        cpu_iorq_n;
    logic        cpu_rd_n;
    logic        cpu_wr_n;
    logic        cpu_m1_n;
    logic [7:0]  cpu_dout;
    logic        update_addr;
    logic        data_reverse;
    logic [7:0]  cpu_din;
    logic [7:0]  ext_data_in;
    logic [7:0]  ext_data_out;
    logic        ext_data_oe;
    logic        ext_mreq_n;
    logic        ext_iorq_n;
    logic        ext_rd_n;
    logic        ext_wr_n;
    logic [1:0]  msel;
    logic [7:0]  mp;
    logic [21:0] mem_addr;
    logic        mem_read;
    logic        mem_write;
    logic [7:0]  mem_rdata;

    integer seed = 32'h8b858dee;

    // reference copy of the slot and mapper registers
    logic [7:0] pri_model;
    logic [7:0] exp_model;
    logic [7:0] map_model [4];

    msx_bus_bridge uut (.*);

    initial begin
        clk_108m = 1'b0;
        forever #(CLK_PERIOD / 2) clk_108m = ~clk_108m;
    end

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("Watchdog expired: tests did not finish in %0d clock cycles", TEST_CYCLES * 2);
        $display("** FAIL **");
        $fatal(1, "simulation timed out");
    end

    // ------------------------------------------------------------
    // reference rules
    // ------------------------------------------------------------
    function automatic logic [1:0] field_of(input logic [7:0] reg_byte, input logic [15:0] addr);
        return reg_byte[2 * addr[15:14] +: 2];
    endfunction

    function automatic logic in_slot0(input logic [15:0] addr);
        return field_of(pri_model, addr) == 2'd0;
    endfunction

    function automatic logic in_mapper(input logic [15:0] addr);
        return in_slot0(addr) && (field_of(exp_model, addr) == 2'd3) && (addr != 16'hFFFF);
    endfunction

    function automatic logic [21:0] mapped_addr(input logic [15:0] addr);
        return {map_model[addr[15:14]], addr[13:0]};
    endfunction

    function automatic logic [7:0] read_value(input logic [15:0] addr, input logic [7:0] ext_byte,
                                              input logic [7:0] mem_byte);
        if (in_mapper(addr)) begin
            return mem_byte;
        end else if (in_slot0(addr) && addr == 16'hFFFF) begin
            return ~exp_model;
        end else if (in_slot0(addr)) begin
            return 8'hFF;
        end
        return ext_byte;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [13:0] random_offset();
        logic [31:0] r;
        r = $random(seed);
        return r[13:0];
    endfunction

    // ------------------------------------------------------------
    // bus cycle tasks
    // ------------------------------------------------------------
    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic next_drive();
        @(posedge clk_108m);
        #DRIVE_DLY;
    endtask

    // phase 0 lies before the first edge that samples the strobe
    task automatic hold_strobes(input logic rd_out, input logic wr_out);
        for (int i = 0; i < HOLD_PHASES; i++) begin
            @(negedge clk_108m);
            check_eq(ext_rd_n, !(rd_out && i > STROBE_DELAY), "ext_rd_n");
            check_eq(ext_wr_n, !(wr_out && i > STROBE_DELAY), "ext_wr_n");
            next_drive();
        end
    endtask

    task automatic release_bus();
        cpu_mreq_n   = 1'b1;
        cpu_iorq_n   = 1'b1;
        cpu_rd_n     = 1'b1;
        cpu_wr_n     = 1'b1;
        data_reverse = 1'b0;
        @(negedge clk_108m);
        check_eq(ext_rd_n, 1'b1, "ext_rd_n after release");
        check_eq(ext_wr_n, 1'b1, "ext_wr_n after release");
        check_eq(ext_mreq_n, 1'b1, "ext_mreq_n after release");
        check_eq(ext_iorq_n, 1'b1, "ext_iorq_n after release");
        repeat (IDLE_CYCLES) next_drive();
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        cpu_addr   = {random_byte(), port};
        cpu_dout   = data;
        cpu_m1_n   = 1'b1;
        cpu_iorq_n = 1'b0;
        cpu_wr_n   = 1'b0;
        #SETTLE_DLY;
        check_eq(ext_iorq_n, 1'b0, "ext_iorq_n on I/O write");
        check_eq(ext_mreq_n, 1'b1, "ext_mreq_n on I/O write");
        check_eq(mem_write, 1'b0, "mem_write on I/O write");
        hold_strobes(1'b0, 1'b1);
        release_bus();
        if (port == 8'hA8) begin
            pri_model = data;
        end
        if (port[7:2] == 6'h3F) begin
            map_model[port[1:0]] = data;
        end
    endtask

    task automatic mem_read_cycle(input logic [15:0] addr);
        logic [7:0] ext_byte;
        logic [7:0] mem_byte;
        logic       slot0;
        logic       mapper;
        ext_byte    = random_byte();
        mem_byte    = random_byte();
        if (mem_byte == ext_byte) begin
            mem_byte = ~ext_byte;
        end
        slot0       = in_slot0(addr);
        mapper      = in_mapper(addr);
        ext_data_in = ext_byte;
        mem_rdata   = mem_byte;
        cpu_addr    = addr;
        cpu_m1_n    = 1'b1;
        cpu_mreq_n  = 1'b0;
        cpu_rd_n    = 1'b0;
        #SETTLE_DLY;
        check_eq(cpu_din, read_value(addr, ext_byte, mem_byte), "cpu_din");
        check_eq(ext_mreq_n, slot0, "ext_mreq_n on read");
        check_eq(mem_read, mapper, "mem_read");
        check_eq(mem_write, 1'b0, "mem_write on read");
        check_eq(ext_data_oe, 1'b0, "ext_data_oe on read");
        if (mapper) begin
            check_eq(mem_addr, mapped_addr(addr), "mem_addr on read");
        end
        hold_strobes(!slot0, 1'b0);
        release_bus();
    endtask

    task automatic mem_write_cycle(input logic [15:0] addr, input logic [7:0] data);
        logic slot0;
        logic mapper;
        slot0        = in_slot0(addr);
        mapper       = in_mapper(addr);
        cpu_addr     = addr;
        cpu_dout     = data;
        data_reverse = 1'b1;
        cpu_m1_n     = 1'b1;
        cpu_mreq_n   = 1'b0;
        cpu_wr_n     = 1'b0;
        #SETTLE_DLY;
        check_eq(ext_mreq_n, slot0, "ext_mreq_n on write");
        check_eq(mem_write, mapper, "mem_write");
        check_eq(mem_read, 1'b0, "mem_read on write");
        check_eq(ext_data_oe, 1'b1, "ext_data_oe on write");
        check_eq(ext_data_out, slot0 ? 8'hFF : data, "ext_data_out");
        if (mapper) begin
            check_eq(mem_addr, mapped_addr(addr), "mem_addr on write");
        end
        hold_strobes(1'b0, !slot0);
        release_bus();
        if (slot0 && addr == 16'hFFFF) begin
            exp_model = data;
        end
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic test_reset_defaults();
        logic [15:0] addr;
        @(negedge clk_108m);
        check_eq(ext_mreq_n, 1'b1, "ext_mreq_n after reset");
        check_eq(ext_iorq_n, 1'b1, "ext_iorq_n after reset");
        check_eq(ext_rd_n, 1'b1, "ext_rd_n after reset");
        check_eq(ext_wr_n, 1'b1, "ext_wr_n after reset");
        check_eq(msel, 2'b00, "msel after reset");
        check_eq(ext_data_oe, 1'b0, "ext_data_oe after reset");
        check_eq(mp, cpu_addr[15:8], "mp after reset");
        next_drive();
        // sub-slot 3 in every page
        mem_write_cycle(16'hFFFF, 8'hFF);
        for (int p = 0; p < 4; p++) begin
            addr = {2'(p), random_offset()};
            if (addr == 16'hFFFF) begin
                addr = 16'hFFFE;
            end
            mem_read_cycle(addr);
            check_eq(mem_addr[21:14], 3 - p, "mapper segment after reset");
        end
    endtask

    task automatic test_primary_slot();
        // pages 0 and 1 on sub-slot 0, pages 2 and 3 on the mapper
        mem_write_cycle(16'hFFFF, 8'hF0);
        // page 1 moves to slot 1
        io_write(8'hA8, 8'b00_00_01_00);
        mem_read_cycle({2'd0, random_offset()});
        mem_read_cycle({2'd1, random_offset()});
        mem_write_cycle({2'd1, random_offset()}, random_byte());
    endtask

    task automatic test_expanded_slot();
        mem_write_cycle(16'hFFFF, random_byte());
        mem_read_cycle(16'hFFFF);
    endtask

    task automatic test_mapper();
        logic [15:0] addr;
        io_write(8'hA8, 8'h00);
        mem_write_cycle(16'hFFFF, 8'hFF);
        for (int p = 0; p < 4; p++) begin
            io_write(8'hFC + 8'(p), random_byte());
        end
        for (int p = 0; p < 4; p++) begin
            addr = {2'(p), random_offset()};
            if (addr == 16'hFFFF) begin
                addr = 16'hFFFE;
            end
            mem_read_cycle(addr);
            mem_write_cycle(addr, random_byte());
        end
    endtask

    // cycle k is the clock after edge k and edge 0 samples update_addr first
    task automatic test_addr_demux();
        logic [15:0] addr;
        addr = {random_byte(), random_byte()};
        if (addr[15:8] == addr[7:0]) begin
            addr[7:0] = ~addr[7:0];
        end
        cpu_addr    = addr;
        update_addr = 1'b1;
        for (int k = 0; k < 12; k++) begin
            @(posedge clk_108m);
            @(negedge clk_108m);
            check_eq(msel[1], (k >= 2 && k <= 4), "msel[1]");
            check_eq(msel[0], (k >= 7 && k <= 9), "msel[0]");
            check_eq(mp, (k >= 6) ? addr[7:0] : addr[15:8], "mp");
        end
        next_drive();
        update_addr = 1'b0;
        repeat (2) @(posedge clk_108m);
        @(negedge clk_108m);
        check_eq(mp, addr[15:8], "mp back on high byte");
        next_drive();
    endtask

    task automatic test_strobe_delay();
        // page 3 moves to slot 2 on the cartridge bus
        io_write(8'hA8, 8'b10_00_00_00);
        mem_read_cycle({2'd3, random_offset()});
        mem_write_cycle({2'd3, random_offset()}, random_byte());
    endtask

    initial begin
        bus_reset_n  = 1'b0;
        cpu_addr     = 16'hA55A;
        cpu_mreq_n   = 1'b1;
        cpu_iorq_n   = 1'b1;
        cpu_rd_n     = 1'b1;
        cpu_wr_n     = 1'b1;
        cpu_m1_n     = 1'b1;
        cpu_dout     = 8'h00;
        update_addr  = 1'b0;
        data_reverse = 1'b0;
        ext_data_in  = 8'h00;
        mem_rdata    = 8'h00;
        pri_model    = 8'h00;
        exp_model    = 8'h00;
        map_model[0] = 8'd3;
        map_model[1] = 8'd2;
        map_model[2] = 8'd1;
        map_model[3] = 8'd0;
        repeat (RESET_CYCLES) @(posedge clk_108m);
        #DRIVE_DLY;
        bus_reset_n = 1'b1;

        test_reset_defaults();
        test_primary_slot();
        test_expanded_slot();
        test_mapper();
        test_addr_demux();
        test_strobe_delay();

        $display("** PASS **");
        $finish;
    end

endmodule

/* src/msx_bus_bridge.sv */
`timescale 1ns/1ps

`include "msx_bus_cfg.svh"

module msx_bus_bridge (
    input  logic                        clk_108m,
    input  logic                        bus_reset_n,

    // CPU side
    input  msx_bus_pkg::addr_t          cpu_addr,
    input  logic                        cpu_mreq_n,
    input  logic                        cpu_iorq_n,
    input  logic                        cpu_rd_n,
    input  logic                        cpu_wr_n,
    input  logic                        cpu_m1_n,
    input  msx_bus_pkg::data_t          cpu_dout,
    input  logic                        update_addr,
    input  logic                        data_reverse,
    output msx_bus_pkg::data_t          cpu_din,

    // external cartridge bus
    input  msx_bus_pkg::data_t          ext_data_in,
    output msx_bus_pkg::data_t          ext_data_out,
    output logic                        ext_data_oe,
    output logic                        ext_mreq_n,
    output logic                        ext_iorq_n,
    output logic                        ext_rd_n,
    output logic                        ext_wr_n,
    output logic [1:0]                  msel,
    output msx_bus_pkg::data_t          mp,

    // mapper memory port
    output logic [`MEM_ADDR_W-1:0]      mem_addr,
    output logic                        mem_read,
    output logic                        mem_write,
    input  msx_bus_pkg::data_t          mem_rdata
);

    import msx_bus_pkg::*;

    logic       slot0_sel;
    page_sel_t  sub_slot;
    logic       exp_read;
    data_t      exp_value;
    logic       mapper_sel;
    logic       int_access;

    // ------------------------------------------------------------
    // slot selection
    // ------------------------------------------------------------
    slot_regs u_slot_regs (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .cpu_addr    (cpu_addr),
        .cpu_mreq_n  (cpu_mreq_n),
        .cpu_iorq_n  (cpu_iorq_n),
        .cpu_rd_n    (cpu_rd_n),
        .cpu_wr_n    (cpu_wr_n),
        .cpu_m1_n    (cpu_m1_n),
        .cpu_dout    (cpu_dout),
        .slot0_sel   (slot0_sel),
        .sub_slot    (sub_slot),
        .exp_read    (exp_read),
        .exp_value   (exp_value)
    );

    memory_mapper u_memory_mapper (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .cpu_addr    (cpu_addr),
        .cpu_mreq_n  (cpu_mreq_n),
        .cpu_iorq_n  (cpu_iorq_n),
        .cpu_rd_n    (cpu_rd_n),
        .cpu_wr_n    (cpu_wr_n),
        .cpu_m1_n    (cpu_m1_n),
        .cpu_dout    (cpu_dout),
        .slot0_sel   (slot0_sel),
        .sub_slot    (sub_slot),
        .mapper_sel  (mapper_sel),
        .mem_addr    (mem_addr),
        .mem_read    (mem_read),
        .mem_write   (mem_write)
    );

    slot_decoder u_slot_decoder (
        .cpu_mreq_n   (cpu_mreq_n),
        .cpu_rd_n     (cpu_rd_n),
        .cpu_wr_n     (cpu_wr_n),
        .cpu_dout     (cpu_dout),
        .data_reverse (data_reverse),
        .slot0_sel    (slot0_sel),
        .exp_read     (exp_read),
        .exp_value    (exp_value),
        .mapper_sel   (mapper_sel),
        .mem_rdata    (mem_rdata),
        .ext_data_in  (ext_data_in),
        .cpu_din      (cpu_din),
        .int_access   (int_access),
        .ext_data_out (ext_data_out),
        .ext_data_oe  (ext_data_oe)
    );

    // ------------------------------------------------------------
    // external bus timing
    // ------------------------------------------------------------
    addr_demux u_addr_demux (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .cpu_addr    (cpu_addr),
        .update_addr (update_addr),
        .msel        (msel),
        .mp          (mp)
    );

    strobe_isolation u_strobe_isolation (
        .clk_108m    (clk_108m),
        .bus_reset_n (bus_reset_n),
        .cpu_mreq_n  (cpu_mreq_n),
        .cpu_iorq_n  (cpu_iorq_n),
        .cpu_rd_n    (cpu_rd_n),
        .cpu_wr_n    (cpu_wr_n),
        .int_access  (int_access),
        .ext_mreq_n  (ext_mreq_n),
        .ext_iorq_n  (ext_iorq_n),
        .ext_rd_n    (ext_rd_n),
        .ext_wr_n    (ext_wr_n)
    );

endmodule

/* src/strobe_isolation.sv */
`timescale 1ns/1ps

`include "msx_bus_cfg.svh"

module strobe_isolation (
    input  logic clk_108m,
    input  logic bus_reset_n,
    input  logic cpu_mreq_n,
    input  logic cpu_iorq_n,
    input  logic cpu_rd_n,
    input  logic cpu_wr_n,
    input  logic int_access,
    output logic ext_mreq_n,
    output logic ext_iorq_n,
    output logic ext_rd_n,
    output logic ext_wr_n
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ACTIVE = 2'd1;
    localparam logic [1:0] ST_WAIT   = 2'd2;

    logic [1:0] state;
    logic [2:0] cnt;
    logic       rd_open_n;
    logic       wr_open_n;

    // strobes fall late but rise together with the CPU
    assign ext_rd_n   = cpu_rd_n || rd_open_n || int_access;
    assign ext_wr_n   = cpu_wr_n || wr_open_n || int_access;
    assign ext_mreq_n = cpu_mreq_n || int_access;
    assign ext_iorq_n = cpu_iorq_n;

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            state     <= ST_IDLE;
            cnt       <= '0;
            rd_open_n <= 1'b1;
            wr_open_n <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    cnt       <= '0;
                    rd_open_n <= 1'b1;
                    wr_open_n <= 1'b1;
                    if (!cpu_rd_n || !cpu_wr_n) begin
                        state <= ST_ACTIVE;
                    end
                end
                ST_ACTIVE: begin
                    if (cnt == 3'(`ISO_DELAY)) begin
                        rd_open_n <= cpu_rd_n;
                        wr_open_n <= cpu_wr_n;
                        state     <= ST_WAIT;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                ST_WAIT: begin
                    if (cpu_rd_n && cpu_wr_n) begin
                        rd_open_n <= 1'b1;
                        wr_open_n <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_no_ext_mreq_internal: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        int_access |-> ext_mreq_n);

    // a read reaches the cartridge only after the full isolation delay
    a_rd_delay: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        $fell(ext_rd_n) |-> $past(!cpu_rd_n, `ISO_DELAY + 2));

endmodule

/* src/addr_demux.sv */
`timescale 1ns/1ps

`include "msx_bus_cfg.svh"

module addr_demux (
    input  logic                clk_108m,
    input  logic                bus_reset_n,
    input  msx_bus_pkg::addr_t  cpu_addr,
    input  logic                update_addr,
    output logic [1:0]          msel,
    output msx_bus_pkg::data_t  mp
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_LATCH  = 2'd1;
    localparam logic [1:0] ST_FINISH = 2'd2;

    // counter values at which each edge of the sequence happens
    localparam logic [3:0] T_HI_ON  = 4'd1;
    localparam logic [3:0] T_HI_OFF = T_HI_ON + 4'(`DEMUX_TON);
    localparam logic [3:0] T_SWAP   = T_HI_OFF + 4'(`DEMUX_TP);
    localparam logic [3:0] T_LO_ON  = T_SWAP + 4'(`DEMUX_TP);
    localparam logic [3:0] T_LO_OFF = T_LO_ON + 4'(`DEMUX_TON);

    logic [1:0] state;
    logic [3:0] cnt;
    logic       low_byte;

    assign mp = low_byte ? cpu_addr[7:0] : cpu_addr[15:8];

    // ------------------------------------------------------------
    // latch sequencer
    // ------------------------------------------------------------
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            state    <= ST_IDLE;
            cnt      <= '0;
            low_byte <= 1'b0;
            msel     <= 2'b00;
        end else begin
            case (state)
                ST_IDLE: begin
                    cnt      <= '0;
                    low_byte <= 1'b0;
                    msel     <= 2'b00;
                    if (update_addr) begin
                        state <= ST_LATCH;
                    end
                end
                ST_LATCH: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == T_HI_ON) begin
                        msel[1] <= 1'b1;
                    end
                    if (cnt == T_HI_OFF) begin
                        msel[1] <= 1'b0;
                    end
                    // give the low byte a clock to settle before its latch
                    if (cnt == T_SWAP) begin
                        low_byte <= 1'b1;
                    end
                    if (cnt == T_LO_ON) begin
                        msel[0] <= 1'b1;
                    end
                    if (cnt == T_LO_OFF) begin
                        msel  <= 2'b00;
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    // one sequence per address update
                    if (!update_addr) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_msel_exclusive: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        !(msel[1] && msel[0]));

    a_hi_latch_width: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        $rose(msel[1]) |-> msel[1] [*`DEMUX_TON] ##1 !msel[1]);

endmodule

/* src/memory_mapper.sv */
`timescale 1ns/1ps

`include "msx_bus_cfg.svh"

module memory_mapper (
    input  logic                    clk_108m,
    input  logic                    bus_reset_n,
    input  msx_bus_pkg::addr_t      cpu_addr,
    input  logic                    cpu_mreq_n,
    input  logic                    cpu_iorq_n,
    input  logic                    cpu_rd_n,
    input  logic                    cpu_wr_n,
    input  logic                    cpu_m1_n,
    input  msx_bus_pkg::data_t      cpu_dout,
    input  logic                    slot0_sel,
    input  msx_bus_pkg::page_sel_t  sub_slot,
    output logic                    mapper_sel,
    output logic [`MEM_ADDR_W-1:0]  mem_addr,
    output logic                    mem_read,
    output logic                    mem_write
);

    localparam int OFS_W = `MEM_ADDR_W - `MAPPER_PAGE_W;

    logic [`MAPPER_PAGE_W-1:0] page_reg [4];
    logic                      reg_wr;

    // I/O writes to FC..FFh pick the page by the low two address bits
    assign reg_wr = !cpu_iorq_n && cpu_m1_n && !cpu_wr_n
                    && (cpu_addr[7:2] == `MAPPER_PORT_HI);

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            page_reg[0] <= `MAPPER_RESET_0;
            page_reg[1] <= `MAPPER_RESET_1;
            page_reg[2] <= `MAPPER_RESET_2;
            page_reg[3] <= `MAPPER_RESET_3;
        end else if (reg_wr) begin
            page_reg[cpu_addr[1:0]] <= cpu_dout;
        end
    end

    // FFFFh belongs to the expander, not to the RAM behind it
    assign mapper_sel = slot0_sel && (sub_slot == `MAPPER_SUBSLOT)
                        && (cpu_addr != `SUBSLOT_REG_ADDR);

    // segment number on top of the 16 KB offset
    assign mem_addr = {page_reg[cpu_addr[15:14]], cpu_addr[OFS_W-1:0]};

    assign mem_read  = mapper_sel && !cpu_mreq_n && !cpu_rd_n;
    assign mem_write = mapper_sel && !cpu_mreq_n && !cpu_wr_n;

endmodule

/* src/slot_decoder.sv */
`timescale 1ns/1ps

module slot_decoder (
    input  logic                cpu_mreq_n,
    input  logic                cpu_rd_n,
    input  logic                cpu_wr_n,
    input  msx_bus_pkg::data_t  cpu_dout,
    input  logic                data_reverse,
    input  logic                slot0_sel,
    input  logic                exp_read,
    input  msx_bus_pkg::data_t  exp_value,
    input  logic                mapper_sel,
    input  msx_bus_pkg::data_t  mem_rdata,
    input  msx_bus_pkg::data_t  ext_data_in,
    output msx_bus_pkg::data_t  cpu_din,
    output logic                int_access,
    output msx_bus_pkg::data_t  ext_data_out,
    output logic                ext_data_oe
);

    logic slot0_rd;
    logic slot0_wr;

    // memory cycles that land in primary slot 0
    assign slot0_rd = !cpu_mreq_n && !cpu_rd_n && slot0_sel;
    assign slot0_wr = !cpu_mreq_n && !cpu_wr_n && slot0_sel;

    // slot 0 is served inside, never on the cartridge bus
    assign int_access = slot0_rd || slot0_wr;

    // ------------------------------------------------------------
    // read data back to the CPU
    // ------------------------------------------------------------
    always_comb begin
        if (slot0_rd && mapper_sel) begin
            cpu_din = mem_rdata;
        end else if (exp_read) begin
            cpu_din = exp_value;
        end else if (slot0_rd) begin
            // unpopulated sub-slots float high
            cpu_din = '1;
        end else begin
            cpu_din = ext_data_in;
        end
    end

    // ------------------------------------------------------------
    // external data bus
    // ------------------------------------------------------------
    // internal writes show FFh outside so cartridges see idle data
    assign ext_data_out = slot0_wr ? '1 : cpu_dout;
    assign ext_data_oe  = data_reverse || slot0_wr;

endmodule

/* src/slot_regs.sv */
`timescale 1ns/1ps

`include "msx_bus_cfg.svh"

module slot_regs (
    input  logic                    clk_108m,
    input  logic                    bus_reset_n,
    input  msx_bus_pkg::addr_t      cpu_addr,
    input  logic                    cpu_mreq_n,
    input  logic                    cpu_iorq_n,
    input  logic                    cpu_rd_n,
    input  logic                    cpu_wr_n,
    input  logic                    cpu_m1_n,
    input  msx_bus_pkg::data_t      cpu_dout,
    output logic                    slot0_sel,
    output msx_bus_pkg::page_sel_t  sub_slot,
    output logic                    exp_read,
    output msx_bus_pkg::data_t      exp_value
);

    import msx_bus_pkg::*;

    slot_sel_u  pri_slot_reg;
    slot_sel_u  exp_slot_reg;
    page_sel_t  cur_page;
    logic       ppi_wr;
    logic       exp_wr;
    logic       at_ffff;

    assign cur_page = cpu_addr[15:14];
    assign at_ffff  = (cpu_addr == `SUBSLOT_REG_ADDR);

    // primary slot of the page being accessed is 0
    assign slot0_sel = (pri_slot_reg.page[cur_page] == 2'd0);
    assign sub_slot  = exp_slot_reg.page[cur_page];

    // ------------------------------------------------------------
    // register write decode
    // ------------------------------------------------------------
    // I/O write to port A8h with m1 inactive
    assign ppi_wr = (cpu_addr[7:0] == `PPI_PORT) && !cpu_iorq_n && cpu_m1_n && !cpu_wr_n;

    // FFFFh only counts as the expander when slot 0 owns page 3
    assign exp_wr   = !cpu_mreq_n && !cpu_wr_n && at_ffff && slot0_sel;
    assign exp_read = !cpu_mreq_n && !cpu_rd_n && at_ffff && slot0_sel;

    // expanded register reads back inverted, as on real hardware
    assign exp_value = ~exp_slot_reg.raw;

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            pri_slot_reg <= '0;
        end else if (ppi_wr) begin
            pri_slot_reg.raw <= cpu_dout;
        end
    end

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            exp_slot_reg <= '0;
        end else if (exp_wr) begin
            exp_slot_reg.raw <= cpu_dout;
        end
    end

endmodule

/* src/msx_bus_pkg.sv */
package msx_bus_pkg;

`include "msx_bus_cfg.svh"

    // bus byte and CPU address
    typedef logic [`MSX_DATA_W-1:0] data_t;
    typedef logic [`MSX_ADDR_W-1:0] addr_t;

    // slot or sub-slot number for one 16 KB page
    typedef logic [1:0] page_sel_t;

    // ------------------------------------------------------------
    // slot register layout
    // ------------------------------------------------------------
    // the CPU writes the register as one byte, while the decoder
    // reads it back as four 2-bit page fields
    typedef union packed {
        data_t              raw;
        page_sel_t [3:0]    page;
    } slot_sel_u;

endpackage

/* src/msx_bus_cfg.svh */
`ifndef MSX_BUS_CFG_SVH
`define MSX_BUS_CFG_SVH

// CPU bus widths
`define MSX_ADDR_W          16
`define MSX_DATA_W          8

// memory mapper geometry
`define MAPPER_PAGE_W       8
`define MEM_ADDR_W          22

// I/O ports and special memory locations
`define PPI_PORT            8'hA8
`define MAPPER_PORT_HI      6'b111111
`define SUBSLOT_REG_ADDR    16'hFFFF

// sub-slot of primary slot 0 holding the mapper RAM
`define MAPPER_SUBSLOT      2'd3

// address demux latch pulse and prefetch, in clocks
`define DEMUX_TON           3
`define DEMUX_TP            1

// counter value at which external rd/wr open
`define ISO_DELAY           2

// mapper page registers after reset
`define MAPPER_RESET_0      8'd3
`define MAPPER_RESET_1      8'd2
`define MAPPER_RESET_2      8'd1
`define MAPPER_RESET_3      8'd0

`endif
